// ==== Bender.yml ====
package:
  name: ahb_mem_subsystem

sources:
  # packages first, then leaf modules up to the top level
  - files:
      - source/ahb_pkg.sv
      - source/soc_map_pkg.sv
      - source/byte_lane_ram.sv
      - source/ahb_ram_slave.sv
      - source/ahb_gpio_slave.sv
      - source/ahb_decoder_mux.sv
      - source/ahb_mem_subsystem.sv

  # testbench, top module tb_top
  - target: simulation
    files:
      - dv/ahb_checker.sv
      - dv/tb_top.sv

// ==== dv/ahb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_checker
    import ahb_pkg::*;
(
    input wire logic     HCLK,
    input wire logic     HRESETn,
    input wire ahb_req_t req,
    input wire ahb_rsp_t rsp,
    input wire hdata_t   gpio_out
);

    localparam int MAX_WAIT = 4;   // longest legal data phase is two cycles.

    string  test_name = "none";
    int     tests = 0;
    int     checks = 0;
    int     errors = 0;
    int     test_checks = 0;
    int     test_errors = 0;

    logic   q_read [$];
    logic   q_err [$];
    hdata_t q_rdata [$];
    hdata_t q_gpio [$];

    logic   in_dp = 1'b0;
    logic   dp_read;
    logic   dp_err;
    hdata_t dp_rdata;
    hdata_t dp_gpio;
    int     waits;
    logic   gpio_due = 1'b0;
    hdata_t gpio_exp;

    task automatic compare(string what, hdata_t exp, hdata_t act);
        checks++;
        test_checks++;
        if (exp !== act)
        begin
            errors++;
            test_errors++;
            $display("** Error %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic report_failure(string msg);
        errors++;
        test_errors++;
        $display("test %s: %s", test_name, msg);
    endtask

    task automatic begin_test(string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests++;
        if (q_read.size() != 0 || in_dp)
        begin
            report_failure("transfers were issued but never answered");
        end
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic add_expected(logic is_read, logic is_err, hdata_t rdata, hdata_t gpio);
        q_read.push_back(is_read);
        q_err.push_back(is_err);
        q_rdata.push_back(rdata);
        q_gpio.push_back(gpio);
    endtask

    task automatic check_idle_state();
        compare("hready", 1, rsp.hready);
        compare("hresp", 0, rsp.hresp);
        compare("gpio_out", 0, gpio_out);
    endtask

    task automatic report_counts();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    endtask

    always @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            in_dp    = 1'b0;
            gpio_due = 1'b0;
        end
        else
        begin
            if (gpio_due)
            begin
                compare("gpio_out", gpio_exp, gpio_out);   // one edge after the write.
                gpio_due = 1'b0;
            end
            if (in_dp && !rsp.hready)
            begin
                waits++;
                compare("hresp in wait", dp_err, rsp.hresp);
                if (!dp_err && waits == 1)
                begin
                    report_failure("zero wait state slave inserted a wait");
                end
                if (waits > MAX_WAIT)
                begin
                    report_failure("data phase never completed");
                    in_dp = 1'b0;
                end
            end
            else if (in_dp)
            begin
                compare("hresp", dp_err, rsp.hresp);
                if (dp_err)
                begin
                    compare("error wait cycles", 1, waits);
                end
                else if (dp_read)
                begin
                    compare("hrdata", dp_rdata, rsp.hrdata);
                end
                gpio_exp = dp_gpio;
                gpio_due = 1'b1;
                in_dp    = 1'b0;
            end
            if (rsp.hready && (req.htrans == NONSEQ || req.htrans == SEQ))
            begin
                if (q_read.size() == 0)
                begin
                    report_failure("DUT accepted a transfer that was not expected");
                end
                else
                begin
                    dp_read  = q_read.pop_front();
                    dp_err   = q_err.pop_front();
                    dp_rdata = q_rdata.pop_front();
                    dp_gpio  = q_gpio.pop_front();
                    waits    = 0;
                    in_dp    = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import ahb_pkg::*, soc_map_pkg::*;
();

    localparam int SEED         = 32'h8410;
    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 5;
    localparam int RESET_CYCLES = 4;
    localparam int N_WORDS      = 256;
    localparam int N_WORD_OPS   = 200;
    localparam int N_SUB_OPS    = 200;
    localparam int N_RAW_PAIRS  = 50;
    localparam int N_GPIO_OPS   = 80;
    localparam int N_ERR_OPS    = 20;
    localparam int N_PLANNED    = N_WORDS + N_WORD_OPS + N_SUB_OPS + 2 * N_RAW_PAIRS
                                + N_GPIO_OPS + 2 * N_ERR_OPS;
    localparam int WATCHDOG_CYCLES = 4 * N_PLANNED + 100;

    logic     HCLK;
    logic     HRESETn;
    ahb_req_t req;
    hdata_t   hwdata;
    hdata_t   gpio_in;
    hdata_t   gpio_out;
    ahb_rsp_t rsp;

    hdata_t   ram_img [N_WORDS];
    hdata_t   gpio_model;
    hdata_t   gpio_in_seen;   // gpio_in of the cycle before the address.
    hdata_t   pend_wdata;

    ahb_mem_subsystem UUT (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .req      (req),
        .hwdata   (hwdata),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .rsp      (rsp)
    );

    ahb_checker chk (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .req      (req),
        .rsp      (rsp),
        .gpio_out (gpio_out)
    );

    initial
    begin
        HCLK = 1'b0;
        forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run exceeded %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // byte, halfword pair or whole word, little endian.
    function automatic lane_mask_t lanes_for(hsize_t size, logic [1:0] lo);
        lane_mask_t m;
        for (int i = 0; i < 4; i++)
        begin
            m[i] = (size == WORD) || (size == HALF && (i / 2) == lo[1])
                || (size == BYTE && i == lo);
        end
        return m;
    endfunction

    function automatic hdata_t merge_lanes(hdata_t old, hdata_t wdata, lane_mask_t m);
        hdata_t res;
        res = old;
        for (int i = 0; i < 4; i++)
        begin
            if (m[i])
            begin
                res[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic step_cycle(output logic ready);
        @(negedge HCLK);
        ready        = rsp.hready;
        gpio_in_seen = gpio_in;
        @(posedge HCLK);
        #DRIVE_DLY;
    endtask

    task automatic idle_cycle();
        logic rdy;
        req    = '{haddr: '0, htrans: IDLE, hwrite: 1'b0, hsize: WORD};
        hwdata = pend_wdata;
        do
        begin
            step_cycle(rdy);
        end
        while (!rdy);
        pend_wdata = $urandom;
    endtask

    // address phase now, its data goes out with the next address.
    task automatic issue(logic wr, haddr_t addr, hsize_t size, hdata_t wdata);
        logic       rdy;
        logic       is_err;
        hdata_t     exp_rd;
        lane_mask_t m;
        req    = '{haddr: addr, htrans: NONSEQ, hwrite: wr, hsize: size};
        hwdata = pend_wdata;
        is_err = 1'b0;
        exp_rd = '0;
        m      = lanes_for(size, addr[1:0]);
        case (addr[31:28])
            4'h0:
            begin
                exp_rd = ram_img[addr[9:2]];
                if (wr)
                begin
                    ram_img[addr[9:2]] = merge_lanes(ram_img[addr[9:2]], wdata, m);
                end
            end
            4'h4:
            begin
                exp_rd = addr[2] ? gpio_in_seen : gpio_model;
                if (wr && !addr[2])
                begin
                    gpio_model = merge_lanes(gpio_model, wdata, m);
                end
            end
            default: is_err = 1'b1;
        endcase
        chk.add_expected(!wr, is_err, exp_rd, gpio_model);
        do
        begin
            step_cycle(rdy);
        end
        while (!rdy);
        pend_wdata = wdata;
    endtask

    task automatic drain();
        repeat (3)
        begin
            idle_cycle();
        end
        chk.finish_test();
    endtask

    function automatic haddr_t ram_addr(logic [7:0] word, logic [1:0] lo);
        return {22'd0, word, lo};
    endfunction

    initial
    begin
        logic [7:0] w;
        hsize_t     size;
        logic [3:0] region;
        haddr_t     err_addr;
        int         op;
        void'($urandom(SEED));
        HRESETn      = 1'b0;
        req          = '{haddr: '0, htrans: IDLE, hwrite: 1'b0, hsize: WORD};
        hwdata       = '0;
        gpio_in      = '0;
        gpio_in_seen = '0;
        gpio_model   = '0;
        pend_wdata   = '0;
        repeat (RESET_CYCLES) @(posedge HCLK);
        #DRIVE_DLY;
        HRESETn = 1'b1;

        chk.begin_test("reset");
        idle_cycle();
        chk.check_idle_state();
        drain();

        chk.begin_test("word_traffic");
        for (int i = 0; i < N_WORDS; i++)
        begin
            issue(1'b1, ram_addr(i[7:0], 2'b00), WORD, $urandom);
        end
        for (int i = 0; i < N_WORD_OPS; i++)
        begin
            issue($urandom % 2, ram_addr($urandom, 2'b00), WORD, $urandom);
        end
        drain();

        chk.begin_test("sub_word");
        for (int i = 0; i < N_SUB_OPS; i++)
        begin
            w  = $urandom % 16;   // small window so lanes get revisited.
            op = $urandom % 3;
            if (op == 0)
                issue(1'b1, ram_addr(w, 2'($urandom)), BYTE, $urandom);
            else if (op == 1)
                issue(1'b1, ram_addr(w, {1'($urandom), 1'b0}), HALF, $urandom);
            else
                issue(1'b0, ram_addr(w, 2'b00), WORD, '0);
        end
        drain();

        chk.begin_test("read_after_write");
        for (int i = 0; i < N_RAW_PAIRS; i++)
        begin
            w    = $urandom;
            size = hsize_t'($urandom % 3);
            issue(1'b1, ram_addr(w, (size == WORD) ? 2'b00 : {1'($urandom), 1'b0}), size,
                  $urandom);
            issue(1'b0, ram_addr(w, 2'b00), WORD, '0);
        end
        drain();

        chk.begin_test("gpio");
        for (int i = 0; i < N_GPIO_OPS; i++)
        begin
            if ($urandom % 2)
            begin
                gpio_in = $urandom;
            end
            size = hsize_t'($urandom % 3);
            case ($urandom % 4)
                0: issue(1'b1, GPIO_BASE | ((size == WORD) ? 0 : ((size == HALF) ?
                         2 * ($urandom % 2) : $urandom % 4)), size, $urandom);
                1: issue(1'b0, GPIO_BASE | GPIO_OUT_OFS, WORD, '0);
                2: issue(1'b0, GPIO_BASE | GPIO_IN_OFS, WORD, '0);
                default: issue(1'b1, GPIO_BASE | GPIO_IN_OFS, WORD, $urandom);
            endcase
        end
        drain();

        chk.begin_test("unmapped");
        for (int i = 0; i < N_ERR_OPS; i++)
        begin
            do
            begin
                region = $urandom;
            end
            while (region == 4'h0 || region == 4'h4);
            err_addr = {region, 28'($urandom)};
            issue($urandom % 2, err_addr, WORD, $urandom);
            issue(1'b0, ram_addr(err_addr[9:2], 2'b00), WORD, '0);   // state left alone.
        end
        drain();

        chk.report_counts();
        if (chk.errors == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/ahb_decoder_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_decoder_mux
    import ahb_pkg::*, soc_map_pkg::*;
(
    input  wire logic     HCLK,
    input  wire logic     HRESETn,
    input  wire ahb_req_t req,
    input  wire ahb_rsp_t ram_rsp,
    input  wire ahb_rsp_t gpio_rsp,
    output logic          ram_sel,
    output logic          gpio_sel,
    output logic          hready_in,
    output ahb_rsp_t      rsp
);

    typedef enum logic [1:0] {
        NONE,
        RAM,
        GPIO,
        ERR
    } region_e;

    typedef enum logic {
        ERR_WAIT,
        ERR_DONE
    } err_state_e;

    logic [REGION_SEL_HI:REGION_SEL_LO] region_bits;
    logic                               valid;
    region_e                            region_next;
    region_e                            dp_q;
    err_state_e                         err_q;

    assign region_bits = req.haddr[REGION_SEL_HI:REGION_SEL_LO];
    assign valid       = req.htrans inside {NONSEQ, SEQ};

    assign ram_sel  = region_bits == RAM_BASE[REGION_SEL_HI:REGION_SEL_LO];
    assign gpio_sel = region_bits == GPIO_BASE[REGION_SEL_HI:REGION_SEL_LO];

    always_comb
    begin
        if (!valid)
            region_next = NONE;
        else if (ram_sel)
            region_next = RAM;
        else if (gpio_sel)
            region_next = GPIO;
        else
            region_next = ERR;   // default slave.
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            dp_q  <= NONE;
            err_q <= ERR_WAIT;
        end
        else if (hready_in)
        begin
            dp_q  <= region_next;
            err_q <= ERR_WAIT;
        end
        else if (dp_q == ERR)
        begin
            err_q <= ERR_DONE;   // second error cycle.
        end
    end

    always_comb
    begin
        case (dp_q)
            RAM:     rsp = ram_rsp;
            GPIO:    rsp = gpio_rsp;
            ERR:     rsp = '{hrdata: '0, hready: (err_q == ERR_DONE), hresp: 1'b1};
            default: rsp = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
        endcase
    end

    assign hready_in = rsp.hready;

    a_one_hot_sel : assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !(ram_sel && gpio_sel)
    );

endmodule

`default_nettype wire

// ==== source/ahb_gpio_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_gpio_slave
    import ahb_pkg::*, soc_map_pkg::*;
(
    input  wire logic     HCLK,
    input  wire logic     HRESETn,
    input  wire logic     sel,
    input  wire ahb_req_t req,
    input  wire logic     hready_in,
    input  wire hdata_t   hwdata,
    input  wire hdata_t   gpio_in,
    output hdata_t        gpio_out,
    output ahb_rsp_t      rsp
);

    logic       accept;
    logic       is_out;
    logic       is_in;
    lane_mask_t wr_mask_q;
    logic       rd_in_q;
    hdata_t     in_meta_q;
    hdata_t     in_sync_q;

    assign accept = sel && hready_in && (req.htrans inside {NONSEQ, SEQ});
    assign is_out = req.haddr[GPIO_OFS_W-1:2] == GPIO_OUT_OFS[GPIO_OFS_W-1:2];
    assign is_in  = req.haddr[GPIO_OFS_W-1:2] == GPIO_IN_OFS[GPIO_OFS_W-1:2];

    always_ff @(posedge HCLK)
    begin
        in_meta_q <= gpio_in;   // two-flop synchronizer.
        in_sync_q <= in_meta_q;
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            wr_mask_q <= '0;
            rd_in_q   <= 1'b0;
        end
        else
        begin
            // writes to the input register fall through with an empty mask.
            wr_mask_q <= (accept && req.hwrite && is_out) ?
                         lane_mask(req.hsize, req.haddr[1:0]) : '0;
            if (accept)
            begin
                rd_in_q <= is_in;
            end
        end
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            gpio_out <= '0;
        end
        else
        begin
            for (int i = 0; i < LANES; i++)
            begin
                if (wr_mask_q[i])
                begin
                    gpio_out[i*8 +: 8] <= hwdata[i*8 +: 8];
                end
            end
        end
    end

    assign rsp = '{hrdata: rd_in_q ? in_sync_q : gpio_out, hready: 1'b1, hresp: 1'b0};

endmodule

`default_nettype wire

// ==== source/ahb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_mem_subsystem
    import ahb_pkg::*;
(
    input  wire logic     HCLK,
    input  wire logic     HRESETn,
    input  wire ahb_req_t req,
    input  wire hdata_t   hwdata,
    input  wire hdata_t   gpio_in,
    output hdata_t        gpio_out,
    output ahb_rsp_t      rsp
);

    logic     ram_sel;
    logic     gpio_sel;
    logic     hready_in;
    ahb_rsp_t ram_rsp;
    ahb_rsp_t gpio_rsp;

    ahb_decoder_mux u_decoder (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .req       (req),
        .ram_rsp   (ram_rsp),
        .gpio_rsp  (gpio_rsp),
        .ram_sel   (ram_sel),
        .gpio_sel  (gpio_sel),
        .hready_in (hready_in),
        .rsp       (rsp)
    );

    ahb_ram_slave u_ram (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .sel       (ram_sel),
        .req       (req),
        .hready_in (hready_in),
        .hwdata    (hwdata),
        .rsp       (ram_rsp)
    );

    ahb_gpio_slave u_gpio (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .sel       (gpio_sel),
        .req       (req),
        .hready_in (hready_in),
        .hwdata    (hwdata),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .rsp       (gpio_rsp)
    );

endmodule

`default_nettype wire

// ==== source/ahb_pkg.sv ====
`default_nettype none

package ahb_pkg;

    localparam int unsigned HADDR_W = 32;
    localparam int unsigned HDATA_W = 32;
    localparam int unsigned LANES   = HDATA_W / 8;

    typedef logic [HADDR_W-1:0] haddr_t;
    typedef logic [HDATA_W-1:0] hdata_t;
    typedef logic [LANES-1:0]   lane_mask_t;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    // address phase only.
    typedef struct packed {
        haddr_t  haddr;
        htrans_t htrans;
        logic    hwrite;
        hsize_t  hsize;
    } ahb_req_t;

    typedef struct packed {
        hdata_t hrdata;
        logic   hready;
        logic   hresp;
    } ahb_rsp_t;

    // byte lanes touched by a little endian transfer.
    function automatic lane_mask_t lane_mask(hsize_t size, logic [1:0] addr_lo);
        case (size)
            BYTE:    return lane_mask_t'(4'b0001 << addr_lo);
            HALF:    return addr_lo[1] ? 4'b1100 : 4'b0011;
            WORD:    return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== source/ahb_ram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_ram_slave
    import ahb_pkg::*, soc_map_pkg::*;
(
    input  wire logic     HCLK,
    input  wire logic     HRESETn,
    input  wire logic     sel,
    input  wire ahb_req_t req,
    input  wire logic     hready_in,
    input  wire hdata_t   hwdata,
    output ahb_rsp_t      rsp
);

    logic           accept;
    ram_word_addr_t rd_addr;
    logic           raw_hit;
    logic           acc_q;
    logic           wr_q;
    ram_word_addr_t waddr_q;
    lane_mask_t     mask_q;
    lane_mask_t     fwd_mask_q;
    hdata_t         fwd_data_q;
    hdata_t         ram_rdata;
    hdata_t         hrdata;

    assign accept  = sel && hready_in && (req.htrans inside {NONSEQ, SEQ});
    assign rd_addr = req.haddr[RAM_WORD_ADDR_W+1:2];

    // read accepted while a write to the same word is still in its data phase.
    assign raw_hit = accept && !req.hwrite && (mask_q != '0) && (rd_addr == waddr_q);

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            acc_q      <= 1'b0;
            wr_q       <= 1'b0;
            mask_q     <= '0;
            fwd_mask_q <= '0;
        end
        else
        begin
            acc_q      <= accept;
            wr_q       <= accept && req.hwrite;
            mask_q     <= (accept && req.hwrite) ? lane_mask(req.hsize, req.haddr[1:0]) : '0;
            fwd_mask_q <= raw_hit ? mask_q : '0;
        end
    end

    always_ff @(posedge HCLK)
    begin
        if (accept)
        begin
            waddr_q <= rd_addr;
        end
        fwd_data_q <= hwdata;   // write data of the pending phase.
    end

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        byte_lane_ram u_lane (
            .HCLK         (HCLK),
            .read_addr    (rd_addr),
            .write_addr   (waddr_q),
            .write_data   (hwdata[i*8 +: 8]),
            .write_enable (mask_q[i]),
            .read_data    (ram_rdata[i*8 +: 8])
        );

        assign hrdata[i*8 +: 8] = fwd_mask_q[i] ? fwd_data_q[i*8 +: 8] : ram_rdata[i*8 +: 8];
    end

    assign rsp = '{hrdata: hrdata, hready: 1'b1, hresp: 1'b0};   // zero wait state.

    a_mask_only_in_write : assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !(acc_q && wr_q) |-> (mask_q == '0)
    );

    a_hsize_max_word : assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        accept |-> (req.hsize <= WORD)
    );

endmodule

`default_nettype wire

// ==== source/byte_lane_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_lane_ram
    import soc_map_pkg::*;
(
    input  wire logic           HCLK,
    input  wire ram_word_addr_t read_addr,
    input  wire ram_word_addr_t write_addr,
    input  wire logic [7:0]     write_data,
    input  wire logic           write_enable,
    output logic [7:0]          read_data
);

    logic [7:0] mem [2**RAM_WORD_ADDR_W];

    always_ff @(posedge HCLK)
    begin
        if (write_enable)
        begin
            mem[write_addr] <= write_data;
        end
        read_data <= mem[read_addr];   // old data on a same-address write.
    end

endmodule

`default_nettype wire

// ==== source/soc_map_pkg.sv ====
`default_nettype none

package soc_map_pkg;

    localparam logic [31:0] RAM_BASE  = 32'h0000_0000;
    localparam logic [31:0] GPIO_BASE = 32'h4000_0000;

    // region decode bits of haddr.
    localparam int unsigned REGION_SEL_HI = 31;
    localparam int unsigned REGION_SEL_LO = 28;

    localparam int unsigned RAM_WORD_ADDR_W = 8;   // 256 words, 1 KB.

    localparam int unsigned GPIO_OFS_W = 3;
    localparam logic [GPIO_OFS_W-1:0] GPIO_OUT_OFS = 3'h0;
    localparam logic [GPIO_OFS_W-1:0] GPIO_IN_OFS  = 3'h4;

    typedef logic [RAM_WORD_ADDR_W-1:0] ram_word_addr_t;

endpackage

`default_nettype wire

// ==== tb.f ====
source/ahb_pkg.sv
source/soc_map_pkg.sv
source/byte_lane_ram.sv
source/ahb_ram_slave.sv
source/ahb_gpio_slave.sv
source/ahb_decoder_mux.sv
source/ahb_mem_subsystem.sv
dv/ahb_checker.sv
dv/tb_top.sv
